// ==== verilog/axi_mstr_regs.svh ====
/* Register map of the AXI master command block */
`ifndef AXI_MSTR_REGS_SVH
`define AXI_MSTR_REGS_SVH

// Register offsets on the configuration bus
`define CCR_ADDR   8'h00
`define CAHR_ADDR  8'h04
`define CALR_ADDR  8'h08
`define CWDR_ADDR  8'h0C
`define CRDR_ADDR  8'h10

// CCR bit positions
`define CCR_GO_BIT     0
`define CCR_DONE_BIT   1
`define CCR_RDWRB_BIT  2

// Readback of an unmapped offset
`define CFG_UNMAPPED   32'hFFFF_FFFF

`endif

// ==== verilog/axi_mstr_pkg.sv ====
/* Shared types for the single-beat AXI master
   Bus widths, configuration bus and AXI channel payloads, sequencer states */
package axi_mstr_pkg;

   // ----------------------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------------------

   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 512;
   // One strobe bit per data byte
   localparam int AXI_STRB_W = 64;
   localparam int AXI_ID_W   = 16;
   localparam int CFG_DATA_W = 32;
   // Only the low offset byte reaches this block
   localparam int CFG_ADDR_W = 8;

   // ----------------------------------------------------------------------
   // Configuration bus
   // ----------------------------------------------------------------------

   // Host request, held stable until ack
   typedef struct packed {
      logic                  wr;
      logic                  rd;
      logic [CFG_ADDR_W-1:0] addr;
      logic [CFG_DATA_W-1:0] wdata;
   } cfg_req_t;

   // Single-cycle ack with readback data
   typedef struct packed {
      logic                  ack;
      logic [CFG_DATA_W-1:0] rdata;
   } cfg_rsp_t;

   // Command from the register block to the sequencer and lane steering
   typedef struct packed {
      logic                  go;
      logic                  rd_wrb;
      logic [AXI_ADDR_W-1:0] addr;
      logic [CFG_DATA_W-1:0] wdata;
   } mstr_cmd_t;

   // ----------------------------------------------------------------------
   // AXI channel payloads
   // ----------------------------------------------------------------------

   // AW payload, also carried on AR
   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_ADDR_W-1:0] addr;
      logic [7:0]            len;
      logic [2:0]            size;
   } axi_aw_t;

   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic [AXI_STRB_W-1:0] strb;
      logic                  last;
   } axi_w_t;

   typedef struct packed {
      logic [AXI_ID_W-1:0]   id;
      logic [AXI_DATA_W-1:0] data;
      logic [1:0]            resp;
      logic                  last;
   } axi_r_t;

   typedef struct packed {
      logic [AXI_ID_W-1:0] id;
      logic [1:0]          resp;
   } axi_b_t;

   // Sequencer states, write path then read path
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      WR      = 3'd1,
      WR_DATA = 3'd2,
      WR_RESP = 3'd3,
      RD      = 3'd4,
      RD_DATA = 3'd5
   } mstr_state_e;

endpackage

// ==== verilog/cfg_cmd_regs.sv ====
/* Command register block of the AXI master
   Host bus handshake, CCR/CAHR/CALR/CWDR/CRDR, readback and done interrupt */
`timescale 1ns/1ps
`include "axi_mstr_regs.svh"

module cfg_cmd_regs (
   input  logic                                aclk,
   input  logic                                aresetn,
   input  axi_mstr_pkg::cfg_req_t              cfg_req,
   output axi_mstr_pkg::cfg_rsp_t              cfg_rsp,
   output axi_mstr_pkg::mstr_cmd_t             cmd,
   output logic                                done,
   input  logic                                idle,
   input  logic                                done_set,
   input  logic                                rd_load,
   input  logic [axi_mstr_pkg::CFG_DATA_W-1:0] rd_word,
   output logic                                done_irq_req
);
   import axi_mstr_pkg::*;

   // Host access
   cfg_req_t              req_q;
   logic                  stretch_q;
   logic                  ack_q;
   logic                  wr_en;
   logic [CFG_DATA_W-1:0] rdata_q;

   // Command registers
   logic                  go_q;
   logic                  done_q;
   logic                  done_qq;
   logic                  rd_wrb_q;
   logic [CFG_DATA_W-1:0] cahr_q;
   logic [CFG_DATA_W-1:0] calr_q;
   logic [CFG_DATA_W-1:0] cwdr_q;
   logic [CFG_DATA_W-1:0] crdr_q;
   logic [CFG_DATA_W-1:0] ccr_word;

   // ----------------------------------------------------------------------
   // Host request stretch and ack
   // ----------------------------------------------------------------------

   // Capture address and data on the strobe
   always_ff @(posedge aclk) begin
      if (cfg_req.wr || cfg_req.rd) begin
         req_q <= cfg_req;
      end
   end

   // Stretch spans strobe to ack; ack is one cycle, one edge after stretch
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         stretch_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         stretch_q <= cfg_req.wr || cfg_req.rd || (stretch_q && !ack_q);
         ack_q     <= stretch_q && !ack_q;
      end
   end

   // Register update lands on the same edge that raises ack
   assign wr_en = stretch_q && !ack_q && req_q.wr;

   // ----------------------------------------------------------------------
   // Command registers
   // ----------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         go_q     <= 1'b0;
         done_q   <= 1'b0;
         rd_wrb_q <= 1'b0;
         cahr_q   <= '0;
         calr_q   <= '0;
         cwdr_q   <= '0;
         crdr_q   <= '0;
      end else begin
         // Go drops once the sequencer has left IDLE
         go_q   <= go_q && idle;
         // Sticky until software clears it
         done_q <= done_q || done_set;
         if (rd_load) begin
            crdr_q <= rd_word;
         end
         // Host write has priority over hardware updates
         if (wr_en) begin
            case (req_q.addr)
               `CCR_ADDR: begin
                  go_q     <= req_q.wdata[`CCR_GO_BIT];
                  done_q   <= req_q.wdata[`CCR_DONE_BIT];
                  rd_wrb_q <= req_q.wdata[`CCR_RDWRB_BIT];
               end
               `CAHR_ADDR: cahr_q <= req_q.wdata;
               `CALR_ADDR: calr_q <= req_q.wdata;
               `CWDR_ADDR: cwdr_q <= req_q.wdata;
               `CRDR_ADDR: crdr_q <= req_q.wdata;
               default: ;
            endcase
         end
      end
   end

   // ----------------------------------------------------------------------
   // Readback
   // ----------------------------------------------------------------------

   // CCR image, reserved bits read zero
   always_comb begin
      ccr_word                 = '0;
      ccr_word[`CCR_GO_BIT]    = go_q;
      ccr_word[`CCR_DONE_BIT]  = done_q;
      ccr_word[`CCR_RDWRB_BIT] = rd_wrb_q;
   end

   // Registered mux, settles before ack rises
   always_ff @(posedge aclk) begin
      case (req_q.addr)
         `CCR_ADDR:  rdata_q <= ccr_word;
         `CAHR_ADDR: rdata_q <= cahr_q;
         `CALR_ADDR: rdata_q <= calr_q;
         `CWDR_ADDR: rdata_q <= cwdr_q;
         `CRDR_ADDR: rdata_q <= crdr_q;
         default:    rdata_q <= `CFG_UNMAPPED;
      endcase
   end

   assign cfg_rsp = '{ack: ack_q, rdata: rdata_q};

   // ----------------------------------------------------------------------
   // Command out and done interrupt
   // ----------------------------------------------------------------------

   assign cmd  = '{go: go_q, rd_wrb: rd_wrb_q, addr: {cahr_q, calr_q}, wdata: cwdr_q};
   assign done = done_q;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         done_qq <= 1'b0;
      end else begin
         done_qq <= done_q;
      end
   end

   // Rising edge of Done, one cycle wide
   assign done_irq_req = done_q && !done_qq;

endmodule

// ==== verilog/axi_cmd_fsm.sv ====
/* Single-beat AXI transfer sequencer
   Walks AW, W, B for a write or AR, R for a read, one state per channel */
`timescale 1ns/1ps

module axi_cmd_fsm (
   input  logic                    aclk,
   input  logic                    aresetn,
   input  axi_mstr_pkg::mstr_cmd_t cmd,
   input  logic                    done,
   output axi_mstr_pkg::axi_aw_t   aw,
   output logic                    awvalid,
   input  logic                    awready,
   output logic                    wvalid,
   input  logic                    wready,
   input  logic                    bvalid,
   output logic                    bready,
   output axi_mstr_pkg::axi_aw_t   ar,
   output logic                    arvalid,
   input  logic                    arready,
   input  logic                    rvalid,
   output logic                    rready,
   output logic                    idle,
   output logic                    done_set,
   output logic                    rd_load
);
   import axi_mstr_pkg::*;

   mstr_state_e state_q;
   mstr_state_e state_d;
   axi_aw_t     addr_beat;

   // ----------------------------------------------------------------------
   // Next state
   // ----------------------------------------------------------------------

   always_comb begin
      // Hold by default, every wait is open ended
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // New command only while Done is clear
            if (cmd.go && !done) begin
               state_d = cmd.rd_wrb ? RD : WR;
            end
         end
         WR:      if (awready) state_d = WR_DATA;
         WR_DATA: if (wready)  state_d = WR_RESP;
         WR_RESP: if (bvalid)  state_d = IDLE;
         RD:      if (arready) state_d = RD_DATA;
         RD_DATA: if (rvalid)  state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ----------------------------------------------------------------------
   // Channel controls
   // ----------------------------------------------------------------------

   // Each handshake signal decoded straight from its state
   assign awvalid = (state_q == WR);
   assign wvalid  = (state_q == WR_DATA);
   assign bready  = (state_q == WR_RESP);
   assign arvalid = (state_q == RD);
   assign rready  = (state_q == RD_DATA);

   // ID 0, one beat, 4-byte size
   assign addr_beat = '{id: '0, addr: cmd.addr, len: 8'd0, size: 3'b010};
   assign aw        = addr_beat;
   assign ar        = addr_beat;

   // Status back to the register block
   assign idle     = (state_q == IDLE);
   assign rd_load  = (state_q == RD_DATA) && rvalid;
   // Final handshake of either path
   assign done_set = ((state_q == WR_RESP) && bvalid) || rd_load;

endmodule

// ==== verilog/axi_lane_steer.sv ====
/* Byte-lane steering between the 32-bit command word and the 512-bit beat */
`timescale 1ns/1ps

module axi_lane_steer (
   input  logic [5:0]                          addr_lo,
   input  logic [axi_mstr_pkg::CFG_DATA_W-1:0] wdata,
   output axi_mstr_pkg::axi_w_t                w,
   input  logic [axi_mstr_pkg::AXI_DATA_W-1:0] rdata,
   output logic [axi_mstr_pkg::CFG_DATA_W-1:0] rd_word
);
   import axi_mstr_pkg::*;

   // Bit shift is eight per byte of offset
   logic [8:0]            bit_shift;
   logic [AXI_DATA_W-1:0] wr_wide;
   logic [AXI_DATA_W-1:0] rd_shift;

   assign bit_shift = {addr_lo, 3'b000};

   // ----------------------------------------------------------------------
   // Write lanes
   // ----------------------------------------------------------------------

   // Zero-extend, then move up to the addressed byte
   assign wr_wide = {{(AXI_DATA_W-CFG_DATA_W){1'b0}}, wdata};

   // Offsets past 60 lose the top bytes off the end of the beat
   assign w.data = wr_wide << bit_shift;
   // Four byte enables from the same offset
   assign w.strb = {{(AXI_STRB_W-4){1'b0}}, 4'hF} << addr_lo;
   // Single beat
   assign w.last = 1'b1;

   // ----------------------------------------------------------------------
   // Read lanes
   // ----------------------------------------------------------------------

   assign rd_shift = rdata >> bit_shift;
   assign rd_word  = rd_shift[CFG_DATA_W-1:0];

endmodule

// ==== verilog/axi_mstr_top.sv ====
/* Register-programmed single-beat AXI master
   Host registers drive one 32-bit write or read on a 512-bit AXI bus */
`timescale 1ns/1ps

module axi_mstr_top (
   input  logic                    aclk,
   input  logic                    aresetn,
   // Configuration bus
   input  axi_mstr_pkg::cfg_req_t  cfg_req,
   output axi_mstr_pkg::cfg_rsp_t  cfg_rsp,
   // Write address
   output axi_mstr_pkg::axi_aw_t   aw,
   output logic                    awvalid,
   input  logic                    awready,
   // Write data
   output axi_mstr_pkg::axi_w_t    w,
   output logic                    wvalid,
   input  logic                    wready,
   // Write response
   input  axi_mstr_pkg::axi_b_t    b,
   input  logic                    bvalid,
   output logic                    bready,
   // Read address
   output axi_mstr_pkg::axi_aw_t   ar,
   output logic                    arvalid,
   input  logic                    arready,
   // Read data
   input  axi_mstr_pkg::axi_r_t    r,
   input  logic                    rvalid,
   output logic                    rready,
   output logic                    done_irq_req
);
   import axi_mstr_pkg::*;

   mstr_cmd_t             cmd;
   logic                  done;
   logic                  idle;
   logic                  done_set;
   logic                  rd_load;
   logic [CFG_DATA_W-1:0] rd_word;

   // Host registers and interrupt
   cfg_cmd_regs regs_i (
      .aclk(aclk), .aresetn(aresetn),
      .cfg_req(cfg_req), .cfg_rsp(cfg_rsp),
      .cmd(cmd), .done(done),
      .idle(idle), .done_set(done_set), .rd_load(rd_load), .rd_word(rd_word),
      .done_irq_req(done_irq_req)
   );

   // Channel sequencing
   axi_cmd_fsm fsm_i (
      .aclk(aclk), .aresetn(aresetn),
      .cmd(cmd), .done(done),
      .aw(aw), .awvalid(awvalid), .awready(awready),
      .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bready(bready),
      .ar(ar), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rready(rready),
      .idle(idle), .done_set(done_set), .rd_load(rd_load)
   );

   // Lane placement by the low address bits
   axi_lane_steer steer_i (
      .addr_lo(cmd.addr[5:0]), .wdata(cmd.wdata), .w(w),
      .rdata(r.data), .rd_word(rd_word)
   );

endmodule

// ==== test/axi_mem_model.sv ====
/* Behavioral AXI slave memory for the master testbench
   Sparse byte store, strobed writes, random ready and valid delays */
`timescale 1ns/1ps

module axi_mem_model (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  axi_mstr_pkg::axi_aw_t aw,
   input  logic                  awvalid,
   output logic                  awready,
   input  axi_mstr_pkg::axi_w_t  w,
   input  logic                  wvalid,
   output logic                  wready,
   output axi_mstr_pkg::axi_b_t  b,
   output logic                  bvalid,
   input  logic                  bready,
   input  axi_mstr_pkg::axi_aw_t ar,
   input  logic                  arvalid,
   output logic                  arready,
   output axi_mstr_pkg::axi_r_t  r,
   output logic                  rvalid,
   input  logic                  rready
);
   import axi_mstr_pkg::*;

   // Sparse memory, one entry per written byte
   logic [7:0]  mem [logic [63:0]];
   logic [31:0] rng = 32'h70398596;

   // LCG for the handshake delays
   function automatic logic [31:0] rand32();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   // Unwritten bytes read as a fold of the full address
   function automatic logic [7:0] peek_byte(input logic [63:0] a);
      logic [7:0] f;
      f = 8'h5A;
      for (int i = 0; i < 8; i++) begin
         f ^= a[8*i +: 8];
      end
      return mem.exists(a) ? mem[a] : f;
   endfunction

   initial begin
      logic [63:0] wr_base;
      logic [63:0] rd_base;
      logic        b_owed;
      logic        r_owed;
      logic        b_hs;
      logic        r_hs;
      logic [31:0] rv;
      {awready, wready, arready, bvalid, rvalid} = '0;
      b = '0;
      r = '0;
      {b_owed, r_owed, b_hs, r_hs} = '0;
      wr_base = '0;
      rd_base = '0;
      forever begin
         // ---------------------------------------------------------------
         // Handshakes seen at the rising edge
         // ---------------------------------------------------------------
         @(posedge aclk);
         if (aresetn) begin
            // Beat base, the low six bits select lanes only
            if (awvalid && awready) wr_base = {aw.addr[63:6], 6'd0};
            if (arvalid && arready) begin
               rd_base = {ar.addr[63:6], 6'd0};
               r_owed  = 1'b1;
            end
            if (wvalid && wready) begin
               for (int i = 0; i < AXI_STRB_W; i++) begin
                  if (w.strb[i]) mem[wr_base + i] = w.data[8*i +: 8];
               end
               b_owed = 1'b1;
            end
            b_hs = bvalid && bready;
            r_hs = rvalid && rready;
         end
         // ---------------------------------------------------------------
         // Outputs change at the falling edge
         // ---------------------------------------------------------------
         @(negedge aclk);
         if (!aresetn) begin
            {awready, wready, arready, bvalid, rvalid} = '0;
            {b_owed, r_owed, b_hs, r_hs} = '0;
         end else begin
            rv = rand32();
            // Ready about three cycles in four
            awready = (rv[17:16] != 2'b00);
            wready  = (rv[19:18] != 2'b00);
            arready = (rv[21:20] != 2'b00);
            if (b_hs) begin
               bvalid = 1'b0;
            end else if (b_owed && rv[22]) begin
               b      = '{id: '0, resp: 2'b00};
               bvalid = 1'b1;
               b_owed = 1'b0;
            end
            if (r_hs) begin
               rvalid = 1'b0;
            end else if (r_owed && rv[23]) begin
               for (int i = 0; i < AXI_STRB_W; i++) begin
                  r.data[8*i +: 8] = peek_byte(rd_base + i);
               end
               r.id   = '0;
               r.resp = 2'b00;
               r.last = 1'b1;
               rvalid = 1'b1;
               r_owed = 1'b0;
            end
            {b_hs, r_hs} = '0;
         end
      end
   end

endmodule

// ==== test/tb_axi_mstr.sv ====
/* Testbench for the register-programmed AXI master
   Host register tasks, single-beat commands against a model memory, protocol checks */
`timescale 1ns/1ps
`include "axi_mstr_regs.svh"

module tb_axi_mstr;
   import axi_mstr_pkg::*;

   localparam int TIMEOUT = 200;

   logic     aclk;
   logic     aresetn;
   cfg_req_t cfg_req;
   cfg_rsp_t cfg_rsp;
   axi_aw_t  aw;
   axi_aw_t  ar;
   axi_w_t   w;
   axi_b_t   b;
   axi_r_t   r;
   logic     awvalid;
   logic     awready;
   logic     wvalid;
   logic     wready;
   logic     bvalid;
   logic     bready;
   logic     arvalid;
   logic     arready;
   logic     rvalid;
   logic     rready;
   logic     done_irq_req;

   // Expected AXI payload of the running command
   axi_aw_t               exp_ax   = '0;
   logic [AXI_DATA_W-1:0] exp_data = '0;
   logic [AXI_STRB_W-1:0] exp_strb = '0;
   // Reference memory of bytes written through the DUT
   logic [7:0]  ref_mem [logic [63:0]];
   logic [31:0] rng = 32'h70398596;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          irq_total = 0;
   logic        hung = 1'b0;

   axi_mstr_top  dut_i (.*);
   axi_mem_model mem_i (.*);

   initial begin
      aclk = 1'b0;
      forever #2 aclk = ~aclk;
   end

   always @(posedge aclk) begin
      if (aresetn && done_irq_req) irq_total++;
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------

   function automatic logic [31:0] rand32();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   task automatic flag_value(input string name, input logic [AXI_DATA_W-1:0] got, exp);
      errors++;
      $display("[ERROR] %s: got %0h expected %0h", name, got, exp);
   endtask

   task automatic flag_fail(input string msg);
      errors++;
      $display("[ERROR] %s", msg);
   endtask

   // Later waits fall straight through once one has timed out
   task automatic hang(input string msg);
      if (!hung) flag_fail({"timeout: ", msg});
      hung = 1'b1;
   endtask

   // Model memory byte with the address fold for unwritten bytes
   function automatic logic [7:0] ref_byte(input logic [63:0] a);
      logic [7:0] f;
      f = 8'h5A;
      for (int i = 0; i < 8; i++) begin
         f ^= a[8*i +: 8];
      end
      return ref_mem.exists(a) ? ref_mem[a] : f;
   endfunction

   // Bytes past the end of the beat read as zero
   function automatic logic [31:0] ref_word(input logic [63:0] addr);
      logic [31:0] word;
      int          off;
      word = '0;
      off  = addr[5:0];
      for (int k = 0; k < 4; k++) begin
         if (off + k < 64) word[8*k +: 8] = ref_byte(addr + k);
      end
      return word;
   endfunction

   // Word bytes go to lanes offset..offset+3 of the beat
   task automatic expect_beat(input logic [63:0] addr, input logic [31:0] word);
      int off;
      off      = addr[5:0];
      // ID 0, one beat of 4 bytes
      exp_ax   = '{id: '0, addr: addr, len: 8'd0, size: 3'b010};
      exp_data = '0;
      exp_strb = '0;
      for (int k = 0; k < 4; k++) begin
         if (off + k < 64) begin
            exp_data[8*(off+k) +: 8] = word[8*k +: 8];
            exp_strb[off+k]          = 1'b1;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Configuration bus
   // ----------------------------------------------------------------------

   task automatic cfg_access(input logic is_wr, input logic [7:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
      int n;
      @(negedge aclk);
      cfg_req = '{wr: is_wr, rd: !is_wr, addr: addr, wdata: data};
      @(negedge aclk);
      // Strobe drops after one cycle while address and data hold until ack
      cfg_req.wr = 1'b0;
      cfg_req.rd = 1'b0;
      n = 0;
      while (!cfg_rsp.ack && n < TIMEOUT && !hung) begin
         @(negedge aclk);
         n++;
      end
      if (n >= TIMEOUT) hang("no ack on the configuration bus");
      rdata = cfg_rsp.rdata;
   endtask

   task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      cfg_access(1'b1, addr, data, unused);
   endtask

   task automatic cfg_read(input logic [7:0] addr, output logic [31:0] data);
      cfg_access(1'b0, addr, 32'h0, data);
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      cfg_read(addr, got);
      assert (got == exp)
         else flag_value($sformatf("cfg_rsp.rdata at %h", addr), got, exp);
   endtask

   // ----------------------------------------------------------------------
   // One command, Go to Done, then Done cleared
   // ----------------------------------------------------------------------

   task automatic run_cmd(input logic rd, input logic [63:0] addr, input logic [31:0] word);
      logic [31:0] ccr;
      logic [31:0] got;
      int          irq_before;
      int          n;
      expect_beat(addr, word);
      cfg_write(`CAHR_ADDR, addr[63:32]);
      cfg_write(`CALR_ADDR, addr[31:0]);
      cfg_write(`CWDR_ADDR, word);
      irq_before                  = irq_total;
      ccr                         = '0;
      ccr[`CCR_GO_BIT]            = 1'b1;
      ccr[`CCR_RDWRB_BIT]         = rd;
      cfg_write(`CCR_ADDR, ccr);
      // Poll Done by register reads
      n = 0;
      cfg_read(`CCR_ADDR, ccr);
      while (!ccr[`CCR_DONE_BIT] && n < TIMEOUT && !hung) begin
         cfg_read(`CCR_ADDR, ccr);
         n++;
      end
      if (n >= TIMEOUT) hang("Done never set after Go");
      n = 0;
      while (irq_total == irq_before && n < TIMEOUT && !hung) begin
         @(negedge aclk);
         n++;
      end
      if (n >= TIMEOUT) hang("no done interrupt");
      assert (irq_total - irq_before == 1)
         else flag_value("done_irq_req count", irq_total - irq_before, 1);
      if (rd) begin
         cfg_read(`CRDR_ADDR, got);
         assert (got == ref_word(addr)) else flag_value("CRDR", got, ref_word(addr));
      end else begin
         for (int k = 0; k < 4; k++) begin
            if (addr[5:0] + k < 64) begin
               ref_mem[addr + k] = word[8*k +: 8];
               assert (mem_i.peek_byte(addr + k) == word[8*k +: 8])
                  else flag_value("model memory byte", mem_i.peek_byte(addr + k),
                                  word[8*k +: 8]);
            end
         end
      end
      cfg_write(`CCR_ADDR, 32'h0);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors != test_errors) begin
         tests_failed++;
         $display("Test %0d %s: failed", tests_run, name);
      end else begin
         $display("Test %0d %s: ok", tests_run, name);
      end
      test_errors = errors;
   endtask

   // ----------------------------------------------------------------------
   // Protocol assertions
   // ----------------------------------------------------------------------

   ack_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
      cfg_rsp.ack |=> !cfg_rsp.ack)
      else flag_value("cfg_rsp.ack", 1'b1, 1'b0);
   irq_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
      done_irq_req |=> !done_irq_req)
      else flag_value("done_irq_req", 1'b1, 1'b0);

   // Valid and payload held until the slave takes them
   aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      awvalid && !awready |=> awvalid && $stable(aw))
      else flag_fail("awvalid or aw changed before awready");
   w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid && !wready |=> wvalid && $stable(w))
      else flag_fail("wvalid or w changed before wready");
   ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid && !arready |=> arvalid && $stable(ar))
      else flag_fail("arvalid or ar changed before arready");

   // Response and read data accepted right after the request
   b_ready: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid && wready |=> bready)
      else flag_fail("bready not raised after the W handshake");
   r_ready: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid && arready |=> rready)
      else flag_fail("rready not raised after the AR handshake");

   aw_payload: assert property (@(posedge aclk) disable iff (!aresetn)
      awvalid |-> aw == exp_ax)
      else flag_value("aw", $sampled(aw), exp_ax);
   ar_payload: assert property (@(posedge aclk) disable iff (!aresetn)
      arvalid |-> ar == exp_ax)
      else flag_value("ar", $sampled(ar), exp_ax);
   w_data: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid |-> w.data == exp_data)
      else flag_value("w.data", $sampled(w.data), exp_data);
   w_strb: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid |-> w.strb == exp_strb)
      else flag_value("w.strb", $sampled(w.strb), exp_strb);
   w_last: assert property (@(posedge aclk) disable iff (!aresetn)
      wvalid |-> w.last)
      else flag_fail("w.last low on the single write beat");

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------

   initial begin
      logic [63:0] addr;
      logic [63:0] base;
      logic [31:0] word;
      logic [31:0] val;
      logic        started;
      cfg_req = '0;
      aresetn = 1'b0;
      repeat (4) @(posedge aclk);
      @(negedge aclk);
      aresetn = 1'b1;

      check_reg(`CCR_ADDR, 32'h0);
      check_reg(`CAHR_ADDR, 32'h0);
      check_reg(`CALR_ADDR, 32'h0);
      check_reg(`CWDR_ADDR, 32'h0);
      check_reg(`CRDR_ADDR, 32'h0);
      check_reg(8'h20, `CFG_UNMAPPED);
      end_test("reset values");

      word = rand32();
      cfg_write(`CAHR_ADDR, word);
      check_reg(`CAHR_ADDR, word);
      word = rand32();
      cfg_write(`CALR_ADDR, word);
      check_reg(`CALR_ADDR, word);
      word = rand32();
      cfg_write(`CWDR_ADDR, word);
      check_reg(`CWDR_ADDR, word);
      end_test("register readback");

      addr = {rand32(), rand32()};
      word = rand32();
      run_cmd(1'b0, addr, word);
      end_test("write command");

      // Same address first and then offsets near the top of the beat
      run_cmd(1'b1, addr, 32'h0);
      base = {rand32(), rand32()} & ~64'h3F;
      run_cmd(1'b0, base + 60, rand32());
      for (int k = 1; k < 4; k++) begin
         run_cmd(1'b1, base + 60 + k, 32'h0);
      end
      run_cmd(1'b1, base + 2, 32'h0);
      end_test("read command");

      // Go with Done set must stay parked
      cfg_write(`CCR_ADDR, 32'h3);
      started = 1'b0;
      for (int n = 0; n < TIMEOUT; n++) begin
         @(negedge aclk);
         if (awvalid || arvalid) started = 1'b1;
      end
      assert (!started) else flag_fail("transfer started while Done was set");
      run_cmd(1'b0, {rand32(), rand32()}, rand32());
      end_test("Go blocked by Done");

      // 512-byte window so reads land on earlier writes
      for (int i = 0; i < 20; i++) begin
         val  = rand32();
         addr = 64'h0000_0040_0000_0000 + val[8:0];
         run_cmd(val[31], addr, rand32());
      end
      end_test("random commands");

      $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/axi_mstr_pkg.sv
verilog/cfg_cmd_regs.sv
verilog/axi_cmd_fsm.sv
verilog/axi_lane_steer.sv
verilog/axi_mstr_top.sv
test/axi_mem_model.sv
test/tb_axi_mstr.sv
